// ==== src.f ====
+incdir+tests
src/glb_param_pkg.sv
src/glb_types_pkg.sv
src/glb_ld_cfg_if.sv
src/glb_bank_rd_if.sv
src/glb_shift.sv
src/glb_ld_dma_cfg.sv
src/glb_bank.sv
src/glb_core_load_dma.sv
src/glb_tile_ld.sv
tests/tb_glb_tile_ld.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_glb_tile_ld -f src.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== tests/glb_ld_ref.svh ====
`ifndef GLB_LD_REF_SVH
`define GLB_LD_REF_SVH

typedef logic [CGRA_DATA_WIDTH-1:0] word_list_t [$];

// 16-bit fibonacci lfsr, taps 16 14 13 11
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
    logic feedback;
    feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
    return {state[14:0], feedback};
endfunction

// expected word list of one descriptor over a bank image
function automatic word_list_t ref_stream(
    input dma_ld_header_t             hdr,
    input logic [BANK_DATA_WIDTH-1:0] image [BANK_ROWS]
);
    word_list_t                 words;
    int                         r0;
    int                         r1;
    int                         offs;
    int                         addr;
    int                         row;
    int                         lane;
    logic [BANK_DATA_WIDTH-1:0] bank_row;
    words = {};
    // a zero range still runs once
    r0 = (hdr.iteration[0].range == '0) ? 1 : int'(hdr.iteration[0].range);
    r1 = (hdr.iteration[1].range == '0) ? 1 : int'(hdr.iteration[1].range);
    for (int i1 = 0; i1 < r1; i1++) begin
        for (int i0 = 0; i0 < r0; i0++) begin
            // strides count words, the address counts bytes
            offs = i0 * int'(hdr.iteration[0].stride) + i1 * int'(hdr.iteration[1].stride);
            addr = (int'(hdr.start_addr) + 2 * offs) % (1 << GLB_ADDR_WIDTH);
            row = (addr >> BANK_BYTE_OFFSET) % BANK_ROWS;
            lane = (addr >> CGRA_BYTE_OFFSET) % (1 << (BANK_BYTE_OFFSET - CGRA_BYTE_OFFSET));
            bank_row = image[row];
            words.push_back(bank_row[lane*CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH]);
        end
    end
    return words;
endfunction

`endif

// ==== tests/tb_glb_tile_ld.sv ====
`timescale 1ns/10ps

module tb_glb_tile_ld;
    import glb_param_pkg::*;
    import glb_types_pkg::*;

    localparam int QUEUE_DEPTH = 2;
    localparam int BANK_RD_LATENCY = 2;
    localparam int BANK_ROWS = 256;
    localparam int ROW_BITS = $clog2(BANK_ROWS);
    localparam int CLK_PERIOD = 40;
    localparam int STIM_DELAY = 2;
    localparam int WAIT_LIMIT = 200;
    // bank fill plus seven stream runs with their register writes
    localparam int WATCHDOG_CYCLES = BANK_ROWS + 7 * (WAIT_LIMIT + 60) + 200;

    logic                       clk;
    logic                       reset;
    logic                       cfg_wr_en;
    logic [CFG_ADDR_WIDTH-1:0]  cfg_addr;
    logic [CFG_DATA_WIDTH-1:0]  cfg_wr_data;
    logic                       bank_wr_en;
    logic [ROW_BITS-1:0]        bank_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] bank_wr_data;
    logic                       strm_start_pulse;
    logic [CGRA_DATA_WIDTH-1:0] stream_data_g2f;
    logic                       stream_data_valid_g2f;
    logic                       stream_g2f_done_pulse;
    logic [QUEUE_DEPTH-1:0]     q_valid;

    logic [BANK_DATA_WIDTH-1:0] bank_image [BANK_ROWS];
    logic [15:0]                lfsr_state;
    logic [CGRA_DATA_WIDTH-1:0] exp_words [$];
    logic                       exp_lasts [$];
    int                         valid_cycles [$];
    int                         cycle;
    int                         word_cnt;
    int                         done_cnt;
    int                         checks;
    int                         errors;
    int                         tests;
    int                         test_errors;
    int                         start_cycle;
    int                         delay_fast;
    int                         delay_slow;
    string                      test_name;
    dma_ld_header_t             desc_a;
    dma_ld_header_t             desc_b;

    `include "glb_ld_ref.svh"

    glb_tile_ld #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .BANK_RD_LATENCY(BANK_RD_LATENCY),
        .BANK_DEPTH     (BANK_ROWS)
    ) glb_tile_ld_inst (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic check_word(input string what, input logic [CGRA_DATA_WIDTH-1:0] got,
                              input logic [CGRA_DATA_WIDTH-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0d ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %0d ns: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_count(input string what, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED %0d ns: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // compare process, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (stream_data_valid_g2f) begin
                valid_cycles.push_back(cycle);
                word_cnt++;
                if (exp_words.size() == 0) begin
                    errors++;
                    $display("unexpected output word %h at %0d ns", stream_data_g2f, $time);
                end else begin
                    check_word("stream word", stream_data_g2f, exp_words.pop_front());
                    check_flag("done with word", stream_g2f_done_pulse, exp_lasts.pop_front());
                end
            end else if (stream_g2f_done_pulse) begin
                check_flag("valid at done", stream_data_valid_g2f, 1'b1);
            end
            if (stream_g2f_done_pulse) begin
                done_cnt++;
            end
        end
    end

    function automatic logic [BANK_DATA_WIDTH-1:0] random_row();
        logic [BANK_DATA_WIDTH-1:0] row;
        row = '0;
        for (int b = 0; b < BANK_DATA_WIDTH; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            row = {row[BANK_DATA_WIDTH-2:0], lfsr_state[0]};
        end
        return row;
    endfunction

    function automatic dma_ld_header_t make_desc(input int start, input int n_act,
            input int n_idle, input int r0, input int s0, input int r1, input int s1);
        dma_ld_header_t hdr;
        hdr = '0;
        hdr.valid = 1'b1;
        hdr.start_addr = GLB_ADDR_WIDTH'(start);
        hdr.num_active_words = MAX_NUM_WORDS_WIDTH'(n_act);
        hdr.num_inactive_words = MAX_NUM_WORDS_WIDTH'(n_idle);
        hdr.iteration[0].range = MAX_NUM_WORDS_WIDTH'(r0);
        hdr.iteration[0].stride = MAX_NUM_WORDS_WIDTH'(s0);
        hdr.iteration[1].range = MAX_NUM_WORDS_WIDTH'(r1);
        hdr.iteration[1].stride = MAX_NUM_WORDS_WIDTH'(s1);
        return hdr;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #STIM_DELAY;
    endtask

    task automatic cfg_write(input int entry, input cfg_field_t field, input int data);
        cfg_wr_en = 1'b1;
        cfg_addr = {entry[0], field};
        cfg_wr_data = CFG_DATA_WIDTH'(data);
        next_cycle();
        cfg_wr_en = 1'b0;
    endtask

    task automatic bank_write(input int row, input logic [BANK_DATA_WIDTH-1:0] data);
        bank_wr_en = 1'b1;
        bank_wr_addr = ROW_BITS'(row);
        bank_wr_data = data;
        next_cycle();
        bank_wr_en = 1'b0;
    endtask

    task automatic set_mode(input ld_dma_mode_t mode);
        cfg_write(0, F_MODE, int'(mode));
    endtask

    task automatic load_entry(input int entry, input dma_ld_header_t hdr);
        cfg_write(entry, F_START_ADDR, int'(hdr.start_addr));
        cfg_write(entry, F_NUM_ACTIVE, int'(hdr.num_active_words));
        cfg_write(entry, F_NUM_INACTIVE, int'(hdr.num_inactive_words));
        cfg_write(entry, F_RANGE0, int'(hdr.iteration[0].range));
        cfg_write(entry, F_STRIDE0, int'(hdr.iteration[0].stride));
        cfg_write(entry, F_RANGE1, int'(hdr.iteration[1].range));
        cfg_write(entry, F_STRIDE1, int'(hdr.iteration[1].stride));
        cfg_write(entry, F_COMMIT, 1);
        // descriptor reaches the DMA two edges after the commit
        repeat (2) next_cycle();
    endtask

    task automatic expect_stream(input dma_ld_header_t hdr);
        word_list_t words;
        words = ref_stream(hdr, bank_image);
        foreach (words[k]) begin
            exp_words.push_back(words[k]);
            exp_lasts.push_back(k == words.size() - 1);
        end
    endtask

    task automatic pulse_start();
        start_cycle = cycle;
        strm_start_pulse = 1'b1;
        next_cycle();
        strm_start_pulse = 1'b0;
    endtask

    task automatic wait_dones(input int target);
        int waited;
        waited = 0;
        while (done_cnt < target && waited < WAIT_LIMIT) begin
            next_cycle();
            waited++;
        end
        if (done_cnt < target) begin
            errors++;
            $display("no done pulse within %0d cycles in test %0d", WAIT_LIMIT, tests);
        end
    endtask

    task automatic run_normal(input dma_ld_header_t hdr, input int target);
        load_entry(0, hdr);
        expect_stream(hdr);
        pulse_start();
        wait_dones(target);
    endtask

    task automatic begin_test(input string name);
        tests++;
        test_name = name;
        test_errors = errors;
        word_cnt = 0;
        done_cnt = 0;
        valid_cycles.delete();
    endtask

    task automatic end_test();
        if (exp_words.size() != 0) begin
            errors++;
            $display("%0d expected words never arrived in test %0d", exp_words.size(), tests);
            exp_words.delete();
            exp_lasts.delete();
        end
        if (errors == test_errors) begin
            $display("test %0d %s: ok", tests, test_name);
        end else begin
            $display("test %0d %s: %0d errors", tests, test_name, errors - test_errors);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        cfg_wr_en = 1'b0;
        cfg_addr = '0;
        cfg_wr_data = '0;
        bank_wr_en = 1'b0;
        bank_wr_addr = '0;
        bank_wr_data = '0;
        strm_start_pulse = 1'b0;
        lfsr_state = 16'd3;
        cycle = 0;
        checks = 0;
        errors = 0;
        tests = 0;
        repeat (3) @(posedge clk);
        #STIM_DELAY;
        reset = 1'b0;
        for (int r = 0; r < BANK_ROWS; r++) begin
            bank_image[r] = random_row();
            bank_write(r, bank_image[r]);
        end

        begin_test("normal 1d stride 1");
        set_mode(NORMAL);
        desc_a = make_desc(12'h010, 8, 0, 8, 1, 1, 0);
        run_normal(desc_a, 1);
        end_test();

        begin_test("2d strided with gaps");
        desc_a = make_desc(12'h040, 3, 2, 4, 3, 3, 16);
        run_normal(desc_a, 1);
        // groups of three words, two idle cycles between groups
        for (int k = 1; k < valid_cycles.size(); k++) begin
            check_count("gap before word", valid_cycles[k] - valid_cycles[k-1],
                        (k % 3 == 0) ? 3 : 1);
        end
        end_test();

        begin_test("latency 0 then 3");
        desc_a = make_desc(12'h100, 4, 1, 6, 2, 2, 8);
        run_normal(desc_a, 1);
        delay_fast = valid_cycles[0] - start_cycle;
        // internal start one cycle after the pulse, first word six cycles later
        check_count("first word delay at latency 0", delay_fast, 7);
        // last words must clear the delay taps before the output tap moves up
        repeat (16) next_cycle();
        cfg_write(0, F_LATENCY, 3);
        valid_cycles.delete();
        run_normal(desc_a, 2);
        delay_slow = valid_cycles[0] - start_cycle;
        check_count("first word shift at latency 3", delay_slow - delay_fast, 3);
        cfg_write(0, F_LATENCY, 0);
        end_test();

        begin_test("off mode ignores start");
        set_mode(OFF);
        load_entry(0, desc_a);
        pulse_start();
        repeat (40) next_cycle();
        check_count("words in off mode", word_cnt, 0);
        check_count("done pulses in off mode", done_cnt, 0);
        check_flag("q_valid[0] in off mode", q_valid[0], 1'b1);
        end_test();

        begin_test("auto increment over two entries");
        desc_a = make_desc(12'h200, 5, 0, 5, 1, 1, 0);
        desc_b = make_desc(12'h300, 2, 1, 3, 5, 2, 7);
        load_entry(0, desc_a);
        load_entry(1, desc_b);
        set_mode(AUTO_INCR);
        expect_stream(desc_a);
        expect_stream(desc_b);
        pulse_start();
        wait_dones(2);
        check_flag("q_valid[0] after both streams", q_valid[0], 1'b0);
        check_flag("q_valid[1] after both streams", q_valid[1], 1'b0);
        set_mode(OFF);
        end_test();

        begin_test("repeat on recommit");
        desc_a = make_desc(12'h080, 4, 0, 4, 4, 2, 1);
        load_entry(0, desc_a);
        set_mode(REPEAT);
        expect_stream(desc_a);
        pulse_start();
        wait_dones(1);
        // second run starts from the commit alone
        expect_stream(desc_a);
        cfg_write(0, F_COMMIT, 1);
        wait_dones(2);
        set_mode(OFF);
        end_test();

        $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== src/glb_tile_ld.sv ====
`timescale 1ns/10ps

module glb_tile_ld #(
    parameter int QUEUE_DEPTH = 2,
    parameter int BANK_RD_LATENCY = 2,
    parameter int BANK_DEPTH = 256
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      cfg_wr_en,
    input  logic [glb_param_pkg::CFG_ADDR_WIDTH-1:0]  cfg_addr,
    input  logic [glb_param_pkg::CFG_DATA_WIDTH-1:0]  cfg_wr_data,
    input  logic                                      bank_wr_en,
    input  logic [$clog2(BANK_DEPTH)-1:0]             bank_wr_addr,
    input  logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] bank_wr_data,
    input  logic                                      strm_start_pulse,
    output logic [glb_param_pkg::CGRA_DATA_WIDTH-1:0] stream_data_g2f,
    output logic                                      stream_data_valid_g2f,
    output logic                                      stream_g2f_done_pulse,
    output logic [QUEUE_DEPTH-1:0]                    q_valid
);

    glb_ld_cfg_if #(.QUEUE_DEPTH(QUEUE_DEPTH)) ld_cfg ();
    glb_bank_rd_if bank_rd ();

    glb_ld_dma_cfg #(.QUEUE_DEPTH(QUEUE_DEPTH)) glb_ld_dma_cfg_inst (
        .cfg(ld_cfg.regs),
        .*
    );

    glb_core_load_dma #(
        .QUEUE_DEPTH    (QUEUE_DEPTH),
        .BANK_RD_LATENCY(BANK_RD_LATENCY)
    ) glb_core_load_dma_inst (
        .cfg(ld_cfg.dma),
        .rd (bank_rd.dma),
        .*
    );

    glb_bank #(
        .BANK_DEPTH     (BANK_DEPTH),
        .BANK_RD_LATENCY(BANK_RD_LATENCY)
    ) glb_bank_inst (
        .rd(bank_rd.bank),
        .*
    );

endmodule

// ==== src/glb_core_load_dma.sv ====
`timescale 1ns/10ps

module glb_core_load_dma #(
    parameter int QUEUE_DEPTH = 2,
    parameter int BANK_RD_LATENCY = 2
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      strm_start_pulse,
    glb_ld_cfg_if.dma                                 cfg,
    glb_bank_rd_if.dma                                rd,
    output logic [glb_param_pkg::CGRA_DATA_WIDTH-1:0] stream_data_g2f,
    output logic                                      stream_data_valid_g2f,
    output logic                                      stream_g2f_done_pulse
);
    import glb_param_pkg::*;
    import glb_types_pkg::*;

    localparam int MAX_LATENCY = (1 << LATENCY_WIDTH) - 1;
    localparam int SHIFT_DEPTH = BANK_RD_LATENCY + MAX_LATENCY + 3;
    localparam int Q_SEL_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    dma_ld_header_t                   hdr_int [QUEUE_DEPTH];
    dma_ld_header_t                   cur_hdr;
    logic [QUEUE_DEPTH-1:0]           valid_d1;
    logic [Q_SEL_WIDTH-1:0]           q_sel;
    logic                             dma_active;
    logic                             start_next;
    logic                             start_pulse_internal;
    logic                             strm_run;
    logic                             strm_active;
    logic [MAX_NUM_WORDS_WIDTH-1:0]   active_cnt;
    logic [MAX_NUM_WORDS_WIDTH-1:0]   inactive_cnt;
    logic [MAX_NUM_WORDS_WIDTH-1:0]   itr [LOOP_LEVEL];
    logic [LOOP_LEVEL-1:0]            itr_wrap;
    logic [LOOP_LEVEL-1:0]            itr_incr;
    logic                             done_internal;
    logic [GLB_ADDR_WIDTH-1:0]        strm_addr;
    logic                             rdrq_en;
    logic [GLB_ADDR_WIDTH-1:0]        rdrq_addr;
    logic                             row_eq;
    logic [0:0]                       start_tap [SHIFT_DEPTH];
    logic [0:0]                       en_tap [SHIFT_DEPTH];
    logic [0:0]                       done_tap [SHIFT_DEPTH];
    logic [GLB_ADDR_WIDTH-1:0]        addr_tap [SHIFT_DEPTH];
    logic [BANK_DATA_WIDTH-1:0]       row_cache;
    logic [BANK_BYTE_OFFSET-CGRA_BYTE_OFFSET-1:0] word_sel;

    // latch a descriptor on its rising valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_d1 <= '0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                hdr_int[i] <= '0;
            end
        end else begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                valid_d1[i] <= cfg.header[i].valid;
                if (cfg.header[i].valid && !valid_d1[i]) begin
                    hdr_int[i] <= cfg.header[i];
                end else if (cfg.invalidate[i]) begin
                    hdr_int[i].valid <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            cfg.invalidate[i] = start_pulse_internal && (q_sel == Q_SEL_WIDTH'(i));
        end
    end

    // REPEAT and AUTO_INCR keep running until the mode changes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dma_active <= 1'b0;
        end else if (cfg.mode == OFF || cfg.mode == NORMAL) begin
            dma_active <= 1'b0;
        end else if (start_pulse_internal) begin
            dma_active <= 1'b1;
        end
    end

    always_comb begin
        case (cfg.mode)
            NORMAL: start_next = strm_start_pulse && !strm_run;
            REPEAT, AUTO_INCR:
                start_next = !strm_run && ((strm_start_pulse && !dma_active) ||
                                           (dma_active && hdr_int[q_sel].valid));
            default: start_next = 1'b0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_pulse_internal <= 1'b0;
        end else begin
            start_pulse_internal <= start_pulse_internal ? 1'b0 : start_next;
        end
    end

    always_ff @(posedge clk) begin
        if (start_pulse_internal) begin
            cur_hdr <= hdr_int[q_sel];
        end
    end

    // run flag and active/inactive duty pattern
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            strm_run <= 1'b0;
            strm_active <= 1'b0;
            active_cnt <= '0;
            inactive_cnt <= '0;
        end else if (start_pulse_internal) begin
            strm_run <= 1'b1;
            strm_active <= 1'b1;
            active_cnt <= hdr_int[q_sel].num_active_words;
            inactive_cnt <= '0;
        end else if (done_internal) begin
            strm_run <= 1'b0;
            strm_active <= 1'b0;
        end else if (strm_run) begin
            if (strm_active) begin
                if (active_cnt <= 1) begin
                    active_cnt <= cur_hdr.num_active_words;
                    if (cur_hdr.num_inactive_words != '0) begin
                        strm_active <= 1'b0;
                        inactive_cnt <= cur_hdr.num_inactive_words;
                    end
                end else begin
                    active_cnt <= active_cnt - 1'b1;
                end
            end else begin
                if (inactive_cnt == 1) begin
                    strm_active <= 1'b1;
                end
                inactive_cnt <= inactive_cnt - 1'b1;
            end
        end
    end

    // nested loop and byte address
    always_comb begin
        for (int i = 0; i < LOOP_LEVEL; i++) begin
            itr_wrap[i] = (cur_hdr.iteration[i].range == '0) ||
                          (itr[i] == cur_hdr.iteration[i].range - 1'b1);
        end
        itr_incr[0] = strm_run && strm_active;
        for (int i = 1; i < LOOP_LEVEL; i++) begin
            itr_incr[i] = itr_incr[i-1] && itr_wrap[i-1];
        end
        done_internal = strm_run && strm_active && (&itr_wrap);
        strm_addr = cur_hdr.start_addr;
        for (int i = 0; i < LOOP_LEVEL; i++) begin
            strm_addr = strm_addr + ((GLB_ADDR_WIDTH'(itr[i]) *
                GLB_ADDR_WIDTH'(cur_hdr.iteration[i].stride)) << CGRA_BYTE_OFFSET);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < LOOP_LEVEL; i++) begin
                itr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < LOOP_LEVEL; i++) begin
                if (start_pulse_internal) begin
                    itr[i] <= '0;
                end else if (itr_incr[i]) begin
                    itr[i] <= itr_wrap[i] ? '0 : itr[i] + 1'b1;
                end
            end
        end
    end

    // one request per active cycle, address held in gaps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rdrq_en <= 1'b0;
            rdrq_addr <= '0;
        end else begin
            rdrq_en <= strm_run && strm_active;
            if (strm_run && strm_active) begin
                rdrq_addr <= strm_addr;
            end
        end
    end

    glb_shift #(.DATA_WIDTH(1), .DEPTH(SHIFT_DEPTH)) glb_shift_start_pulse (
        .clk     (clk),
        .reset   (reset),
        .data_in (start_pulse_internal),
        .data_out(start_tap)
    );

    glb_shift #(.DATA_WIDTH(1), .DEPTH(SHIFT_DEPTH)) glb_shift_rd_en (
        .clk     (clk),
        .reset   (reset),
        .data_in (rdrq_en),
        .data_out(en_tap)
    );

    glb_shift #(.DATA_WIDTH(GLB_ADDR_WIDTH), .DEPTH(SHIFT_DEPTH)) glb_shift_rd_addr (
        .clk     (clk),
        .reset   (reset),
        .data_in (rdrq_addr),
        .data_out(addr_tap)
    );

    glb_shift #(.DATA_WIDTH(1), .DEPTH(SHIFT_DEPTH)) glb_shift_done_pulse (
        .clk     (clk),
        .reset   (reset),
        .data_in (done_internal),
        .data_out(done_tap)
    );

    // bank read goes out after the extra latency, so the cache holds one row per word
    // first request of a stream always reads
    always_comb begin
        row_eq = addr_tap[cfg.latency][GLB_ADDR_WIDTH-1:BANK_BYTE_OFFSET] ==
                 addr_tap[cfg.latency + 1][GLB_ADDR_WIDTH-1:BANK_BYTE_OFFSET];
        rd.rd_en = en_tap[cfg.latency][0] && (start_tap[cfg.latency + 2][0] || !row_eq);
        rd.rd_addr = addr_tap[cfg.latency];
    end

    always_ff @(posedge clk) begin
        if (rd.rd_data_valid) begin
            row_cache <= rd.rd_data;
        end
    end

    always_comb begin
        word_sel = addr_tap[BANK_RD_LATENCY + 1 + cfg.latency][BANK_BYTE_OFFSET-1:CGRA_BYTE_OFFSET];
        stream_data_g2f = row_cache[word_sel*CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH];
        stream_data_valid_g2f = en_tap[BANK_RD_LATENCY + 1 + cfg.latency][0];
        stream_g2f_done_pulse = done_tap[BANK_RD_LATENCY + 2 + cfg.latency][0];
    end

    // queue selection, AUTO_INCR steps at each done
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q_sel <= '0;
        end else if (cfg.mode != AUTO_INCR) begin
            q_sel <= '0;
        end else if (done_internal) begin
            q_sel <= (q_sel == Q_SEL_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : q_sel + 1'b1;
        end
    end

    a_no_restart: assert property (@(posedge clk) disable iff (reset)
        start_pulse_internal |-> !strm_run);

endmodule

// ==== src/glb_bank.sv ====
`timescale 1ns/10ps

module glb_bank #(
    parameter int BANK_DEPTH = 256,
    parameter int BANK_RD_LATENCY = 2
) (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      bank_wr_en,
    input  logic [$clog2(BANK_DEPTH)-1:0]             bank_wr_addr,
    input  logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] bank_wr_data,
    glb_bank_rd_if.bank                               rd
);
    import glb_param_pkg::*;

    localparam int ROW_WIDTH = $clog2(BANK_DEPTH);

    logic [BANK_DATA_WIDTH-1:0] mem [BANK_DEPTH];
    logic [BANK_DATA_WIDTH-1:0] rd_pipe [BANK_RD_LATENCY];
    logic [ROW_WIDTH-1:0]       rd_row;
    logic [0:0]                 valid_tap [BANK_RD_LATENCY];

    // byte address to row index
    assign rd_row = rd.rd_addr[BANK_BYTE_OFFSET +: ROW_WIDTH];

    always_ff @(posedge clk) begin
        if (bank_wr_en) begin
            mem[bank_wr_addr] <= bank_wr_data;
        end
    end

    // several reads may be in flight
    always_ff @(posedge clk) begin
        if (rd.rd_en) begin
            rd_pipe[0] <= mem[rd_row];
        end
        for (int i = 1; i < BANK_RD_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    glb_shift #(.DATA_WIDTH(1), .DEPTH(BANK_RD_LATENCY)) glb_shift_rd_valid (
        .clk     (clk),
        .reset   (reset),
        .data_in (rd.rd_en),
        .data_out(valid_tap)
    );

    assign rd.rd_data = rd_pipe[BANK_RD_LATENCY-1];
    assign rd.rd_data_valid = valid_tap[BANK_RD_LATENCY-1][0];

    a_rd_addr_known: assert property (@(posedge clk) disable iff (reset)
        rd.rd_en |-> !$isunknown(rd.rd_addr));

endmodule

// ==== src/glb_ld_dma_cfg.sv ====
`timescale 1ns/10ps

module glb_ld_dma_cfg #(
    parameter int QUEUE_DEPTH = 2
) (
    input  logic                                     clk,
    input  logic                                     reset,
    input  logic                                     cfg_wr_en,
    input  logic [glb_param_pkg::CFG_ADDR_WIDTH-1:0] cfg_addr,
    input  logic [glb_param_pkg::CFG_DATA_WIDTH-1:0] cfg_wr_data,
    glb_ld_cfg_if.regs                               cfg,
    output logic [QUEUE_DEPTH-1:0]                   q_valid
);
    import glb_param_pkg::*;
    import glb_types_pkg::*;

    localparam int FIELD_WIDTH = $bits(cfg_field_t);

    logic [CFG_ADDR_WIDTH-FIELD_WIDTH-1:0] entry;
    cfg_field_t                            field;
    logic                                  edit;

    assign entry = cfg_addr[CFG_ADDR_WIDTH-1:FIELD_WIDTH];
    assign field = cfg_field_t'(cfg_addr[FIELD_WIDTH-1:0]);
    // editing a queued entry takes it off the queue until the next commit
    assign edit = cfg_wr_en && (field inside {[F_START_ADDR:F_STRIDE1]});

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                cfg.header[i] <= '0;
            end
            cfg.mode <= OFF;
            cfg.latency <= '0;
        end else begin
            if (edit) begin
                cfg.header[entry].valid <= 1'b0;
            end
            if (cfg_wr_en) begin
                case (field)
                    F_START_ADDR: cfg.header[entry].start_addr <= cfg_wr_data[GLB_ADDR_WIDTH-1:0];
                    F_NUM_ACTIVE:
                        cfg.header[entry].num_active_words <= cfg_wr_data[MAX_NUM_WORDS_WIDTH-1:0];
                    F_NUM_INACTIVE:
                        cfg.header[entry].num_inactive_words <= cfg_wr_data[MAX_NUM_WORDS_WIDTH-1:0];
                    F_RANGE0: cfg.header[entry].iteration[0].range <= cfg_wr_data[MAX_NUM_WORDS_WIDTH-1:0];
                    F_STRIDE0: cfg.header[entry].iteration[0].stride <= cfg_wr_data[MAX_NUM_WORDS_WIDTH-1:0];
                    F_RANGE1: cfg.header[entry].iteration[1].range <= cfg_wr_data[MAX_NUM_WORDS_WIDTH-1:0];
                    F_STRIDE1: cfg.header[entry].iteration[1].stride <= cfg_wr_data[MAX_NUM_WORDS_WIDTH-1:0];
                    F_COMMIT: cfg.header[entry].valid <= 1'b1;
                    F_MODE: cfg.mode <= ld_dma_mode_t'(cfg_wr_data[1:0]);
                    F_LATENCY: cfg.latency <= cfg_wr_data[LATENCY_WIDTH-1:0];
                    default: ;
                endcase
            end
            // invalidate from the DMA wins over a commit
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (cfg.invalidate[i]) begin
                    cfg.header[i].valid <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            q_valid[i] = cfg.header[i].valid;
        end
    end

    a_entry_in_range: assert property (@(posedge clk) disable iff (reset)
        cfg_wr_en && !(field inside {F_MODE, F_LATENCY}) |-> int'(entry) < QUEUE_DEPTH);

endmodule

// ==== src/glb_shift.sv ====
`timescale 1ns/10ps

module glb_shift #(
    parameter int DATA_WIDTH = 1,
    parameter int DEPTH = 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out [DEPTH]
);

    // tap i holds data_in from i+1 cycles ago
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                data_out[i] <= '0;
            end
        end else begin
            data_out[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                data_out[i] <= data_out[i-1];
            end
        end
    end

endmodule

// ==== src/glb_bank_rd_if.sv ====
`timescale 1ns/10ps

interface glb_bank_rd_if;
    import glb_param_pkg::*;

    logic                       rd_en;
    // byte address, low bits ignored by the bank
    logic [GLB_ADDR_WIDTH-1:0]  rd_addr;
    logic [BANK_DATA_WIDTH-1:0] rd_data;
    logic                       rd_data_valid;

    modport dma (output rd_en, output rd_addr, input rd_data, input rd_data_valid);

    modport bank (input rd_en, input rd_addr, output rd_data, output rd_data_valid);

endinterface

// ==== src/glb_ld_cfg_if.sv ====
`timescale 1ns/10ps

interface glb_ld_cfg_if #(
    parameter int QUEUE_DEPTH = 2
);
    import glb_param_pkg::*;
    import glb_types_pkg::*;

    dma_ld_header_t           header [QUEUE_DEPTH];
    ld_dma_mode_t             mode;
    logic [LATENCY_WIDTH-1:0] latency;
    // one pulse per entry when the DMA takes it
    logic [QUEUE_DEPTH-1:0]   invalidate;

    modport regs (output header, output mode, output latency, input invalidate);

    modport dma (input header, input mode, input latency, output invalidate);

endinterface

// ==== src/glb_types_pkg.sv ====
package glb_types_pkg;

    typedef enum logic [1:0] {
        OFF       = 2'd0,
        NORMAL    = 2'd1,
        REPEAT    = 2'd2,
        AUTO_INCR = 2'd3
    } ld_dma_mode_t;

    // low four bits of the register address
    typedef enum logic [3:0] {
        F_START_ADDR   = 4'd0,
        F_NUM_ACTIVE   = 4'd1,
        F_NUM_INACTIVE = 4'd2,
        F_RANGE0       = 4'd3,
        F_STRIDE0      = 4'd4,
        F_RANGE1       = 4'd5,
        F_STRIDE1      = 4'd6,
        F_COMMIT       = 4'd7,
        F_MODE         = 4'd8,
        F_LATENCY      = 4'd9
    } cfg_field_t;

    typedef struct packed {
        logic [glb_param_pkg::MAX_NUM_WORDS_WIDTH-1:0] range;
        logic [glb_param_pkg::MAX_NUM_WORDS_WIDTH-1:0] stride;
    } loop_ctrl_t;

    typedef struct packed {
        logic                                          valid;
        logic [glb_param_pkg::GLB_ADDR_WIDTH-1:0]      start_addr;
        logic [glb_param_pkg::MAX_NUM_WORDS_WIDTH-1:0] num_active_words;
        logic [glb_param_pkg::MAX_NUM_WORDS_WIDTH-1:0] num_inactive_words;
        loop_ctrl_t [glb_param_pkg::LOOP_LEVEL-1:0]    iteration;
    } dma_ld_header_t;

endpackage

// ==== src/glb_param_pkg.sv ====
package glb_param_pkg;

    // fabric word and bank row
    localparam int CGRA_DATA_WIDTH = 16;
    localparam int BANK_DATA_WIDTH = 64;

    // byte address into the buffer
    localparam int GLB_ADDR_WIDTH = 12;

    // low address bits inside a word and inside a row
    localparam int CGRA_BYTE_OFFSET = 1;
    localparam int BANK_BYTE_OFFSET = 3;

    // nested loop levels of one descriptor
    localparam int LOOP_LEVEL = 2;

    // loop counters and duty counters
    localparam int MAX_NUM_WORDS_WIDTH = 8;

    // extra output latency setting
    localparam int LATENCY_WIDTH = 3;

    // host register port
    localparam int CFG_ADDR_WIDTH = 5;
    localparam int CFG_DATA_WIDTH = 16;

endpackage
